// File: spi_bridge_defs.svh
// SPI bridge parameters
`ifndef SPI_BRIDGE_DEFS_SVH
`define SPI_BRIDGE_DEFS_SVH

// Register bank depth
`define SPI_REG_COUNT 16

// Register address width, must cover the bank depth
`define SPI_ADDR_W 4

// Read flag in the command byte, bits 6:4 are don't care
`define SPI_CMD_READ_BIT 7

// Start address sits in the low bits of the command byte
// and uses `SPI_ADDR_W bits from bit 0 upwards

`endif

// File: spi_bridge_pkg.sv
// SPI bridge shared types
`include "spi_bridge_defs.svh"

package spi_bridge_pkg;

    // Byte handed from the shifter to the frame engine
    typedef struct packed {
        logic       valid;                  // One-cycle pulse per completed byte
        logic       first;                  // Command byte of the frame
        logic [7:0] data;                   // Received byte, MSB first on the wire
    } rx_byte_t;

    // Wishbone classic master request
    typedef struct packed {
        logic                   cyc;        // Bus cycle in progress
        logic                   stb;        // Strobe, always with cyc here
        logic                   we;         // Write enable
        logic [`SPI_ADDR_W-1:0] adr;        // Register address
        logic [7:0]             dat;        // Write data
    } wb_req_t;

    // Wishbone classic slave response
    typedef struct packed {
        logic       ack;                    // Single-cycle acknowledge
        logic [7:0] dat;                    // Read data, valid with ack
    } wb_rsp_t;

endpackage

// File: spi_byte_shifter.sv
// SPI byte shifter
`timescale 1ns/1ps

module spi_byte_shifter (
    input  logic                     spi_sclk,      // Serial clock, low when the frame opens
    input  logic                     spi_cs_n,      // Chip select, frame reset while high
    input  logic                     spi_rx,        // MOSI
    input  logic [7:0]               tx_byte,       // Byte to serve on MISO
    output logic                     spi_tx,        // MISO
    output spi_bridge_pkg::rx_byte_t rx_byte        // Completed byte with one-cycle valid
);
    import spi_bridge_pkg::*;

    logic [2:0] bit_idx;                            // Bit position in the byte, counts down
    logic [6:0] shift_q;                            // Leading seven bits of the byte in flight
    logic       cmd_seen;                           // Command byte already delivered
    logic       preload;                            // No falling edge seen yet in this frame
    logic       tx_bit;                             // MISO bit launched on the last falling edge
    logic [7:0] tx_q;                               // Transmit byte held for the current byte
    logic       byte_start;                         // This falling edge opens a new byte
    logic [7:0] tx_src;                             // Source of the next MISO bit

    // Receive side, MOSI sampled on rising edges
    always_ff @(posedge spi_sclk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            bit_idx  <= 3'd7;                       // Partial byte of an aborted frame is lost
            cmd_seen <= 1'b0;
            rx_byte  <= '0;
        end else begin
            bit_idx <= bit_idx - 3'd1;              // Wraps to 7 after the last bit
            if (bit_idx == 3'd0) begin
                rx_byte <= rx_byte_t'{valid: 1'b1,
                                      first: ~cmd_seen,
                                      data:  {shift_q, spi_rx}};
                cmd_seen <= 1'b1;
            end else begin
                rx_byte.valid <= 1'b0;              // Data stays until the next byte
            end
        end
    end

    always_ff @(posedge spi_sclk) begin
        shift_q <= {shift_q[5:0], spi_rx};          // Only the low bits are ever used
    end

    // Byte 0 starts on the first falling edge, later bytes when the index wraps
    assign byte_start = preload | (bit_idx == 3'd7);
    assign tx_src     = byte_start ? tx_byte : tx_q; // Engine may move tx_byte mid-byte

    // Transmit side, MISO launched on falling edges
    always_ff @(negedge spi_sclk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            preload <= 1'b1;
            tx_bit  <= 1'b0;
        end else begin
            preload <= 1'b0;
            tx_bit  <= tx_src[bit_idx];             // Index already moved by the rising edge
        end
    end

    always_ff @(negedge spi_sclk) begin
        if (byte_start) begin
            tx_q <= tx_byte;                        // Freeze the byte for its eight bits
        end
    end

    // Bit 7 of byte 0 goes out straight from tx_byte before any clock,
    // which is 0x00 while the engine is held in reset
    assign spi_tx = preload ? tx_byte[7] : tx_bit;

endmodule

// File: spi_frame_engine.sv
// SPI frame engine
`timescale 1ns/1ps
`include "spi_bridge_defs.svh"

module spi_frame_engine (
    input  logic                     spi_sclk,      // Serial clock
    input  logic                     spi_cs_n,      // Frame reset while high
    input  spi_bridge_pkg::rx_byte_t rx_byte,       // Bytes from the shifter
    output logic [7:0]               tx_byte,       // Next MISO byte, latched by the shifter
    output spi_bridge_pkg::wb_req_t  wb_req,        // Wishbone master request
    input  spi_bridge_pkg::wb_rsp_t  wb_rsp         // Wishbone slave response
);
    import spi_bridge_pkg::*;

    logic                   rd_frame;               // Command byte asked for a read
    logic [`SPI_ADDR_W-1:0] addr_q;                 // Address for the next data byte
    logic [`SPI_ADDR_W-1:0] cyc_adr;                // Address of a cycle started now
    logic                   cyc_we;                 // Direction of a cycle started now
    logic                   cmd_rd;                 // Read flag of the byte on rx_byte
    logic                   issue;                  // Start a Wishbone cycle on this edge
    logic                   done;                   // Running cycle acked by the slave

    assign cmd_rd = rx_byte.data[`SPI_CMD_READ_BIT];

    // Command byte carries its own start address, data bytes follow the counter
    assign cyc_adr = rx_byte.first ? rx_byte.data[`SPI_ADDR_W-1:0] : addr_q;

    // Only read frames start a cycle on the command byte, so it is never a write
    assign cyc_we = rx_byte.first ? 1'b0 : ~rd_frame;

    // Write frames skip the command byte, read frames read after every byte
    assign issue = rx_byte.valid & (~rx_byte.first | cmd_rd);

    assign done = wb_req.cyc & wb_rsp.ack;

    // Frame state
    always_ff @(posedge spi_sclk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            rd_frame <= 1'b0;
            addr_q   <= '0;
        end else if (rx_byte.valid) begin
            if (rx_byte.first) begin
                rd_frame <= cmd_rd;                 // Bits 6:4 play no part
            end
            if (issue) begin
                addr_q <= cyc_adr + `SPI_ADDR_W'(1); // Wraps modulo the bank size
            end else begin
                addr_q <= cyc_adr;                  // Write command, first data byte uses it
            end
        end
    end

    // Wishbone master
    // Valid is seen one edge after the byte ends and cyc/stb rise there.
    // The slave acks one cycle later and the master drops cyc/stb on the
    // edge where it sees the ack, long before the next byte completes.
    always_ff @(posedge spi_sclk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            wb_req <= '0;                           // Abort kills any cycle in flight
        end else if (issue) begin
            wb_req <= wb_req_t'{cyc: 1'b1,
                                stb: 1'b1,
                                we:  cyc_we,
                                adr: cyc_adr,
                                dat: rx_byte.data};
        end else if (done) begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;                     // adr, we and dat just hold
        end
    end

    // Read data for MISO
    // A result returned after byte m is picked up by the shifter at the
    // start of byte m+2, so byte 1 of a read frame still sends 0x00
    always_ff @(posedge spi_sclk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            tx_byte <= 8'h00;
        end else if (done && !wb_req.we) begin
            tx_byte <= wb_rsp.dat;                  // Held until the next read returns
        end
    end

endmodule

// File: wb_reg_bank.sv
// Wishbone register bank
`timescale 1ns/1ps
`include "spi_bridge_defs.svh"

module wb_reg_bank (
    input  logic                    spi_sclk,       // Bus clock
    input  logic                    spi_cs_n,       // Clears the ack only
    input  spi_bridge_pkg::wb_req_t wb_req,         // Request from the frame engine
    output spi_bridge_pkg::wb_rsp_t wb_rsp          // Registered response
);
    import spi_bridge_pkg::*;

    logic [7:0] regs [`SPI_REG_COUNT];              // Contents survive between frames
    logic       ack_q;                              // Registered acknowledge
    logic [7:0] dat_q;                              // Read data, captured with the ack
    logic       access;                             // Request not yet acknowledged

    // Ack high means the current request is already served
    assign access = wb_req.cyc & wb_req.stb & ~ack_q;

    // Storage and read port
    always_ff @(posedge spi_sclk) begin
        if (access && wb_req.we) begin
            regs[wb_req.adr] <= wb_req.dat;         // Single write per cycle
        end
        if (access) begin
            dat_q <= regs[wb_req.adr];              // Old value on a write, never used
        end
    end

    // Exactly one ack cycle per request
    always_ff @(posedge spi_sclk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            ack_q <= 1'b0;                          // No stale ack after an abort
        end else begin
            ack_q <= access;
        end
    end

    assign wb_rsp = wb_rsp_t'{ack: ack_q, dat: dat_q};

endmodule

// File: spi_bridge_top.sv
// SPI register bridge top
`timescale 1ns/1ps

module spi_bridge_top (
    input  logic spi_sclk,                          // SPI clock, also the bus clock
    input  logic spi_cs_n,                          // Chip select, active low
    input  logic spi_rx,                            // MOSI
    output logic spi_tx                             // MISO, low between frames
);
    import spi_bridge_pkg::*;

    rx_byte_t   rx_byte;                            // Shifter to engine
    logic [7:0] tx_byte;                            // Engine to shifter
    wb_req_t    wb_req;                             // Engine to bank
    wb_rsp_t    wb_rsp;                             // Bank to engine

    // Serial side
    spi_byte_shifter spi_byte_shifter_inst (
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_rx   (spi_rx),
        .tx_byte  (tx_byte),
        .spi_tx   (spi_tx),
        .rx_byte  (rx_byte)
    );

    // Command decode and Wishbone master
    spi_frame_engine spi_frame_engine_inst (
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .rx_byte  (rx_byte),
        .tx_byte  (tx_byte),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp)
    );

    // Register storage
    wb_reg_bank wb_reg_bank_inst (
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp)
    );

endmodule

// File: spi_bridge_chk.sv
// Wishbone handshake assertions
`timescale 1ns/1ps

module spi_bridge_chk (
    input logic                    spi_sclk,        // Bus clock
    input logic                    spi_cs_n,        // Frame reset disables the checks
    input spi_bridge_pkg::wb_req_t wb_req,          // Engine request
    input spi_bridge_pkg::wb_rsp_t wb_rsp           // Bank response
);
    int fail_count = 0;                             // Read by the testbench top

    // Slave answers only a live request
    ack_in_cycle: assert property (@(posedge spi_sclk) disable iff (spi_cs_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            fail_count++;
            $error("ack seen outside an active Wishbone cycle");
        end

    // Registered ack arrives one cycle after the strobe
    ack_in_time: assert property (@(posedge spi_sclk) disable iff (spi_cs_n)
        (wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack)
        else begin
            fail_count++;
            $error("strobe not acknowledged within one cycle");
        end

    // Strobe never without a cycle
    stb_in_cyc: assert property (@(posedge spi_sclk) disable iff (spi_cs_n)
        wb_req.stb |-> wb_req.cyc)
        else begin
            fail_count++;
            $error("strobe raised without cyc");
        end

endmodule

bind spi_bridge_top spi_bridge_chk spi_bridge_chk_inst (
    .spi_sclk (spi_sclk),
    .spi_cs_n (spi_cs_n),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp)
);

// File: spi_bridge_monitor.sv
// SPI frame monitor
`timescale 1ns/1ps
`include "spi_bridge_defs.svh"

module spi_bridge_monitor (
    input  logic spi_sclk,                          // Sampled on rising edges like the master
    input  logic spi_cs_n,                          // Frame boundary
    input  logic spi_rx,                            // MOSI at the DUT pin
    input  logic spi_tx,                            // MISO at the DUT pin
    input  int   test_id,                           // Running test for error lines
    output int   error_count,                       // MISO mismatches
    output int   check_count                        // Completed bytes compared
);
    logic [7:0]             model [`SPI_REG_COUNT]; // Register contents as written over SPI
    logic [2:0]             bit_cnt;                // Bits received in the current byte
    logic [6:0]             mosi_sr;
    logic [6:0]             miso_sr;
    int                     byte_n;                 // Byte position in the frame
    logic                   read_flag;              // Frame direction from the command byte
    logic [`SPI_ADDR_W-1:0] start_addr;             // Start address from the command byte
    logic [7:0]             mosi_byte;
    logic [7:0]             miso_byte;

    assign mosi_byte = {mosi_sr, spi_rx};
    assign miso_byte = {miso_sr, spi_tx};

    // MISO byte n of a frame as the bridge must send it
    function automatic logic [7:0] expected_miso(input logic rd,
                                                 input logic [`SPI_ADDR_W-1:0] addr,
                                                 input int n);
        logic [`SPI_ADDR_W-1:0] idx;
        if (!rd || n < 2) begin
            return 8'h00;                           // Command slot and write frames
        end
        idx = addr + `SPI_ADDR_W'(n - 2);           // Wraps over the bank
        return model[idx];
    endfunction

    function automatic string test_name(input int id);
        case (id)
            0:       return "bank_fill";
            1:       return "single_write_read";
            2:       return "burst_write_wrap";
            3:       return "burst_read";
            4:       return "zero_bytes";
            5:       return "aborted_frame";
            6:       return "ignored_cmd_bits";
            default: return "unknown";
        endcase
    endfunction

    initial begin
        error_count = 0;
        check_count = 0;
    end

    always @(posedge spi_sclk) begin : compare_proc
        logic [7:0]             exp_v;
        logic                   rd_v;
        logic [`SPI_ADDR_W-1:0] addr_v;
        if (spi_cs_n) begin
            bit_cnt <= 3'd0;                        // Partial byte of an abort is dropped
            byte_n  <= 0;
        end else begin
            mosi_sr <= mosi_byte[6:0];
            miso_sr <= miso_byte[6:0];
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                rd_v   = (byte_n == 0) ? mosi_byte[`SPI_CMD_READ_BIT] : read_flag;
                addr_v = (byte_n == 0) ? mosi_byte[`SPI_ADDR_W-1:0] : start_addr;
                exp_v  = expected_miso(rd_v, addr_v, byte_n);
                check_count <= check_count + 1;
                if (miso_byte !== exp_v) begin
                    error_count <= error_count + 1;
                    $display("FAIL %s byte %0d: expected 0x%02h, actual 0x%02h",
                             test_name(test_id), byte_n, exp_v, miso_byte);
                end
                if (byte_n == 0) begin
                    read_flag  <= rd_v;
                    start_addr <= addr_v;
                end else if (!read_flag) begin
                    model[start_addr + `SPI_ADDR_W'(byte_n - 1)] <= mosi_byte;
                end
                byte_n <= byte_n + 1;
            end
        end
    end

endmodule

// File: tb_spi_bridge.sv
// SPI bridge testbench
`timescale 1ns/1ps
`include "spi_bridge_defs.svh"

module tb_spi_bridge;
    localparam int MAX_CYCLES = 2000;               // About 600 cycles of frames plus margin

    logic       spi_sclk;
    logic       spi_cs_n;
    logic       spi_rx;
    logic       spi_tx;
    int         test_id;
    int         error_count;                        // From the monitor
    int         check_count;
    int         cycle_count;
    int         bytes_sent;                         // Complete bytes the monitor should see
    int         other_errors;
    int         assert_fails;
    logic [7:0] frame_q [$];                        // MOSI bytes of the next frame
    logic [`SPI_ADDR_W-1:0] addr;

    spi_bridge_top spi_bridge_top_inst (
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_rx   (spi_rx),
        .spi_tx   (spi_tx)
    );

    spi_bridge_monitor spi_bridge_monitor_inst (
        .spi_sclk    (spi_sclk),
        .spi_cs_n    (spi_cs_n),
        .spi_rx      (spi_rx),
        .spi_tx      (spi_tx),
        .test_id     (test_id),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        spi_sclk = 1'b0;
        forever #20 spi_sclk = ~spi_sclk;           // 40 ns period
    end

    always @(posedge spi_sclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the frames did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [7:0] cmd_byte(input logic rd, input logic [`SPI_ADDR_W-1:0] a,
                                            input logic [2:0] spare);
        return {rd, spare, a};                      // Bits 6:4 must be ignored
    endfunction

    // Called on a rising edge and returns on one
    task automatic send_frame(input int nbits, input int hold);
        logic [7:0] cur;
        int         b;
        spi_cs_n <= 1'b0;
        for (b = 0; b < nbits; b++) begin
            if (b % 8 == 0) begin
                cur = frame_q[b / 8];
            end
            spi_rx <= cur[7];                       // Sampled on the next rising edge
            cur = {cur[6:0], 1'b0};
            @(posedge spi_sclk);
        end
        repeat (hold) @(posedge spi_sclk);          // Lets the last write land
        spi_cs_n <= 1'b1;
        spi_rx   <= 1'b0;
        bytes_sent += nbits / 8;
        frame_q.delete();
        repeat (2) @(posedge spi_sclk);             // Two cycles deselected
    endtask

    task automatic write_frame(input logic [`SPI_ADDR_W-1:0] a, input int count,
                               input logic [2:0] spare);
        int k;
        frame_q.push_back(cmd_byte(1'b0, a, spare));
        for (k = 0; k < count; k++) begin
            frame_q.push_back(8'($urandom));
        end
        send_frame(8 * (count + 1), 2);
    endtask

    task automatic read_frame(input logic [`SPI_ADDR_W-1:0] a, input int count,
                              input logic [2:0] spare);
        int k;
        frame_q.push_back(cmd_byte(1'b1, a, spare));
        for (k = 1; k < count; k++) begin
            frame_q.push_back(8'($urandom));        // MOSI filler is ignored by the DUT
        end
        send_frame(8 * count, 2);
    endtask

    initial begin
        void'($urandom(70090));
        spi_cs_n     = 1'b1;                        // Frame logic in reset
        spi_rx       = 1'b0;
        test_id      = 0;
        cycle_count  = 0;
        bytes_sent   = 0;
        other_errors = 0;
        repeat (2) @(posedge spi_sclk);
        write_frame(`SPI_ADDR_W'(0), `SPI_REG_COUNT, 3'd0); // Known contents everywhere
        test_id <= 1;
        addr = `SPI_ADDR_W'($urandom);
        write_frame(addr, 1, 3'd0);
        read_frame(addr, 3, 3'd0);
        test_id <= 2;
        write_frame(`SPI_ADDR_W'(14), 6, 3'd0);     // Wraps to 0..3
        read_frame(`SPI_ADDR_W'(14), 8, 3'd0);
        test_id <= 3;
        read_frame(`SPI_ADDR_W'(0), 8, 3'd0);       // Two reads in flight
        test_id <= 4;
        write_frame(`SPI_ADDR_W'($urandom), 3, 3'd0);
        read_frame(`SPI_ADDR_W'($urandom), 2, 3'd0);
        test_id <= 5;
        addr = `SPI_ADDR_W'(9);
        frame_q.push_back(cmd_byte(1'b0, addr, 3'd0));
        frame_q.push_back(8'($urandom));
        send_frame(12, 0);                          // Deselect after half a data byte
        read_frame(addr, 3, 3'd0);
        test_id <= 6;
        write_frame(`SPI_ADDR_W'($urandom), 4, 3'($urandom));
        read_frame(`SPI_ADDR_W'($urandom), 6, 3'($urandom));
        if (check_count != bytes_sent) begin
            $display("Monitor compared %0d bytes but %0d complete bytes were sent",
                     check_count, bytes_sent);
            other_errors++;
        end
        assert_fails = spi_bridge_top_inst.spi_bridge_chk_inst.fail_count;
        $display("Errors: %0d MISO mismatches, %0d assertion failures, %0d other, %0d bytes",
                 error_count, assert_fails, other_errors, check_count);
        if (error_count + assert_fails + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
spi_bridge_pkg.sv
spi_byte_shifter.sv
spi_frame_engine.sv
wb_reg_bank.sv
spi_bridge_top.sv
spi_bridge_chk.sv
spi_bridge_monitor.sv
tb_spi_bridge.sv

// File: run.sh
#!/usr/bin/env bash
# Build the SPI bridge testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module tb_spi_bridge -o sim_spi_bridge

# Keep running after an assertion error so the testbench prints its verdict
./obj_dir/sim_spi_bridge +verilator+error+limit+100 | tee sim.log

if grep -q "Done: no errors" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
